/* Makefile */
# Cartridge loader simulation with Verilator
TOP = cart_loader_tb

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

/* hdl/backup_sector_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
// Backup RAM sector sequencer
// Loads or saves the backup RAM one sector at a time through the
// image request and acknowledge handshake

module backup_sector_sequencer (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire cart_loader_pkg::loader_cfg_t cfg,
	input  wire cart_loader_pkg::image_t image,
	input  wire [23:0]                   ram_mask,
	input  wire                          dl_start,
	input  wire                          dl_end,
	input  wire                          cart_dl,
	input  wire                          sd_ack,
	output cart_loader_pkg::sd_req_t     sd,
	output logic                         bk_ena,
	output logic                         bk_loading
);

	cart_loader_pkg::bk_state_t             state_q;
	logic [cart_loader_pkg::SD_LBA_BITS-1:0] lba_q;
	logic                                   rd_q;
	logic                                   wr_q;
	logic                                   load_q;
	logic                                   save_q;
	logic                                   ack_q;
	logic                                   load_rise;
	logic                                   save_rise;
	logic                                   ack_rise;
	logic                                   ack_fall;
	logic                                   last_sector;

	assign load_rise   = bk_ena & cfg.bk_load & ~load_q;
	assign save_rise   = bk_ena & cfg.bk_save & ~save_q;
	assign ack_rise    = sd_ack & ~ack_q;
	assign ack_fall    = ~sd_ack & ack_q;
	// One sector per 512 bytes of backup RAM
	assign last_sector = lba_q >= {{(cart_loader_pkg::SD_LBA_BITS-15){1'b0}}, ram_mask[23:9]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
			bk_ena <= 1'b0;
		end else begin
			load_q <= cfg.bk_load;
			save_q <= cfg.bk_save;
			ack_q  <= sd_ack;
			if (dl_start) begin
				bk_ena <= 1'b0;
			end
			// Save file is mounted by the time the cartridge streams in
			if (cart_dl && image.mounted && !image.readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	// ==========================================================
	// Sector FSM
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q    <= cart_loader_pkg::BK_IDLE;
			lba_q      <= '0;
			rd_q       <= 1'b0;
			wr_q       <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state_q)
				cart_loader_pkg::BK_IDLE: begin
					if (dl_end && image.size_nonzero && bk_ena) begin
						state_q    <= cart_loader_pkg::BK_WAIT_ACK;
						bk_loading <= 1'b1;
						lba_q      <= '0;
						rd_q       <= 1'b1;
						wr_q       <= 1'b0;
					end else if (load_rise || save_rise) begin
						state_q    <= cart_loader_pkg::BK_WAIT_ACK;
						bk_loading <= load_rise;
						lba_q      <= '0;
						rd_q       <= load_rise;
						wr_q       <= ~load_rise;
					end
				end
				cart_loader_pkg::BK_WAIT_ACK: begin
					if (ack_rise) begin
						rd_q    <= 1'b0;
						wr_q    <= 1'b0;
						state_q <= cart_loader_pkg::BK_WAIT_DONE;
					end
				end
				cart_loader_pkg::BK_WAIT_DONE: begin
					// Falling ack closes the sector
					if (ack_fall) begin
						if (last_sector) begin
							state_q    <= cart_loader_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state_q <= cart_loader_pkg::BK_WAIT_ACK;
							lba_q   <= lba_q + 1'b1;
							rd_q    <= bk_loading;
							wr_q    <= ~bk_loading;
						end
					end
				end
				default: state_q <= cart_loader_pkg::BK_IDLE;
			endcase
		end
	end

	assign sd = '{lba: lba_q, rd: rd_q, wr: wr_q};

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(rd_q && wr_q))
		else $error("sector read and write requested together");

endmodule

`default_nettype wire

/* hdl/cart_loader_pkg.sv */
`default_nettype none
// Cartridge loader shared definitions
// Widths, header constants, mode encodings and the records passed between blocks

package cart_loader_pkg;

	// ==========================================================
	// Widths and constants
	// ==========================================================
	localparam int DL_ADDR_BITS   = 25;
	localparam int DL_DATA_BITS   = 16;
	localparam int FILL_ADDR_BITS = 17;
	localparam int SD_LBA_BITS    = 32;
	localparam int MASK_BITS      = 24;

	// Copier header is skipped when matching header addresses
	localparam logic [DL_ADDR_BITS-1:0] COPIER_HEADER    = 25'h000200;
	localparam logic [DL_ADDR_BITS-1:0] LOROM_HDR_SIZE   = 25'h007FD6;
	localparam logic [DL_ADDR_BITS-1:0] HIROM_HDR_SIZE   = 25'h00FFD6;
	localparam logic [DL_ADDR_BITS-1:0] EXHIROM_HDR_SIZE = 25'h40FFD6;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// Download slots
	localparam logic [7:0] DL_INDEX_CART = 8'h00;
	localparam logic [7:0] DL_INDEX_CODE = 8'hFF;

	// ==========================================================
	// Mode encodings
	// ==========================================================
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_mode_t;

	typedef enum logic [1:0] {
		WRAM_9966 = 2'd0,
		WRAM_00FF = 2'd1,
		WRAM_55   = 2'd2,
		WRAM_FF   = 2'd3
	} wram_pattern_t;

	typedef enum logic [1:0] {
		BK_IDLE      = 2'd0,
		BK_WAIT_ACK  = 2'd1,
		BK_WAIT_DONE = 2'd2
	} bk_state_t;

	// ==========================================================
	// Records
	// ==========================================================
	typedef struct packed {
		logic                    active;
		logic [7:0]              index;
		logic [DL_ADDR_BITS-1:0] addr;
		logic [DL_DATA_BITS-1:0] data;
		logic                    wr;
	} dl_bus_t;

	typedef struct packed {
		header_mode_t  header_mode;
		region_mode_t  region_mode;
		wram_pattern_t wram_pattern;
		logic          bk_load;
		logic          bk_save;
	} loader_cfg_t;

	typedef struct packed {
		logic mounted;
		logic readonly;
		logic size_nonzero;
	} image_t;

	typedef struct packed {
		logic [7:0]           rom_type;
		logic [MASK_BITS-1:0] rom_mask;
		logic [MASK_BITS-1:0] ram_mask;
		logic                 pal;
	} cart_info_t;

	// Word values keep the big endian byte order of the download
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic                      active;
		logic [FILL_ADDR_BITS-1:0] addr;
		logic [7:0]                wram_data;
	} fill_t;

	typedef struct packed {
		logic [SD_LBA_BITS-1:0] lba;
		logic                   rd;
		logic                   wr;
	} sd_req_t;

endpackage

`default_nettype wire

/* hdl/cart_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none
// Cartridge loader top
// Decodes the download stream, makes the start and end pulses and
// holds the console in reset while loading

module cart_loader_top (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire cart_loader_pkg::dl_bus_t     dl,
	input  wire cart_loader_pkg::loader_cfg_t cfg,
	input  wire cart_loader_pkg::image_t      image,
	input  wire                               sd_ack,
	output cart_loader_pkg::cart_info_t       cart,
	output cart_loader_pkg::cheat_code_t      cheat,
	output cart_loader_pkg::fill_t            fill,
	output cart_loader_pkg::sd_req_t          sd,
	output logic                              bk_ena,
	output logic                              bk_loading,
	output logic                              core_reset
);

	logic cart_dl;
	logic cart_dl_q;
	logic cart_dl_start;
	logic cart_dl_end;
	logic code_wr;

	// Index decode
	assign cart_dl = dl.active && dl.index[5:0] == cart_loader_pkg::DL_INDEX_CART[5:0];
	assign code_wr = dl.active && dl.wr && dl.index == cart_loader_pkg::DL_INDEX_CODE;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
		end
	end

	assign cart_dl_start = cart_dl & ~cart_dl_q;
	assign cart_dl_end   = ~cart_dl & cart_dl_q;

	// Console stays in reset until loading and clearing are finished
	assign core_reset = reset | cart_dl | bk_loading | fill.active;

	rom_header_detect u_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cart_dl     (cart_dl),
		.header_mode (cfg.header_mode),
		.region_mode (cfg.region_mode),
		.cart        (cart)
	);

	cheat_code_assembler u_cheat (
		.clk_sys (clk_sys),
		.reset   (reset),
		.code_wr (code_wr),
		.addr    (dl.addr[3:0]),
		.data    (dl.data),
		.cheat   (cheat)
	);

	ram_clear_fill u_fill (
		.clk_sys (clk_sys),
		.reset   (reset),
		.start   (cart_dl_start),
		.pattern (cfg.wram_pattern),
		.fill    (fill)
	);

	backup_sector_sequencer u_backup (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.image      (image),
		.ram_mask   (cart.ram_mask),
		.dl_start   (cart_dl_start),
		.dl_end     (cart_dl_end),
		.cart_dl    (cart_dl),
		.sd_ack     (sd_ack),
		.sd         (sd),
		.bk_ena     (bk_ena),
		.bk_loading (bk_loading)
	);

endmodule

`default_nettype wire

/* hdl/cheat_code_assembler.sv */
`timescale 1ns/1ps
`default_nettype none
// Cheat code assembler
// Gathers eight 16-bit download words into one cheat record

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          code_wr,
	input  wire [3:0]                    addr,
	input  wire [15:0]                   data,
	output cart_loader_pkg::cheat_code_t cheat
);

	logic        valid_q;
	logic [31:0] flags_q;
	logic [31:0] address_q;
	logic [31:0] compare_q;
	logic [31:0] replace_q;

	// Last word of the record clocks the code in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= code_wr && addr == 4'd14;
		end
	end

	// Low word first for every field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (addr)
				4'd0:    flags_q[15:0]    <= data;
				4'd2:    flags_q[31:16]   <= data;
				4'd4:    address_q[15:0]  <= data;
				4'd6:    address_q[31:16] <= data;
				4'd8:    compare_q[15:0]  <= data;
				4'd10:   compare_q[31:16] <= data;
				4'd12:   replace_q[15:0]  <= data;
				4'd14:   replace_q[31:16] <= data;
				default: ;
			endcase
		end
	end

	assign cheat = '{valid: valid_q, flags: flags_q, address: address_q,
		compare: compare_q, replace: replace_q};

	a_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		valid_q |=> !valid_q)
		else $error("cheat valid held for more than one cycle");

endmodule

`default_nettype wire

/* hdl/ram_clear_fill.sv */
`timescale 1ns/1ps
`default_nettype none
// Work RAM clear
// Sweeps the whole fill address range once per cartridge download
// and supplies the start-up pattern byte for each address

module ram_clear_fill (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            start,
	input  wire cart_loader_pkg::wram_pattern_t pattern,
	output cart_loader_pkg::fill_t         fill
);

	logic                                       active_q;
	logic                                       sweep_done_q;
	logic [cart_loader_pkg::FILL_ADDR_BITS-1:0] addr_q;
	logic [7:0]                                 wram_data;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q     <= 1'b0;
			sweep_done_q <= 1'b0;
			addr_q       <= '0;
		end else begin
			// Flags the cycle after the last address
			sweep_done_q <= active_q & (&addr_q);
			if (start) begin
				active_q <= 1'b1;
			end else if (sweep_done_q) begin
				active_q <= 1'b0;
			end
			if (active_q && !sweep_done_q) begin
				addr_q <= addr_q + 1'b1;
			end else begin
				addr_q <= '0;
			end
		end
	end

	// Power-on patterns of the various console revisions
	always_comb begin
		case (pattern)
			cart_loader_pkg::WRAM_9966: wram_data = (addr_q[8] ^ addr_q[2]) ? 8'h66 : 8'h99;
			cart_loader_pkg::WRAM_00FF: wram_data = (addr_q[9] ^ addr_q[0]) ? 8'hFF : 8'h00;
			cart_loader_pkg::WRAM_55:   wram_data = 8'h55;
			default:                    wram_data = 8'hFF;
		endcase
	end

	assign fill = '{active: active_q, addr: addr_q, wram_data: wram_data};

	a_addr_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!active_q |-> addr_q == '0)
		else $error("fill address moved while idle");

endmodule

`default_nettype wire

/* hdl/rom_header_detect.sv */
`timescale 1ns/1ps
`default_nettype none
// ROM header detection
// Picks up size and type bytes from the cartridge download and derives
// the ROM mask, RAM mask and video region

module rom_header_detect (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire cart_loader_pkg::dl_bus_t        dl,
	input  wire                                  cart_dl,
	input  wire cart_loader_pkg::header_mode_t   header_mode,
	input  wire cart_loader_pkg::region_mode_t   region_mode,
	output cart_loader_pkg::cart_info_t          cart
);

	logic [3:0] rom_size_q;
	logic [3:0] ram_size_q;
	logic [3:0] rom_size_nxt;
	logic [3:0] ram_size_nxt;
	logic       region_q;
	logic       hdr_wr;
	logic       fixed_mode;
	logic [7:0] type_nxt;
	logic [cart_loader_pkg::DL_ADDR_BITS-1:0] rom_size_addr;
	logic [cart_loader_pkg::DL_ADDR_BITS-1:0] ram_size_addr;

	assign hdr_wr        = cart_dl & dl.wr;
	assign ram_size_addr = rom_size_addr + 25'd2;

	// Size byte location for the forced layouts
	always_comb begin
		fixed_mode = 1'b1;
		type_nxt   = 8'h00;
		case (header_mode)
			cart_loader_pkg::HDR_LOROM: begin
				rom_size_addr = cart_loader_pkg::LOROM_HDR_SIZE + cart_loader_pkg::COPIER_HEADER;
			end
			cart_loader_pkg::HDR_HIROM: begin
				rom_size_addr = cart_loader_pkg::HIROM_HDR_SIZE + cart_loader_pkg::COPIER_HEADER;
				type_nxt      = 8'h01;
			end
			cart_loader_pkg::HDR_EXHIROM: begin
				rom_size_addr = cart_loader_pkg::EXHIROM_HDR_SIZE + cart_loader_pkg::COPIER_HEADER;
				type_nxt      = 8'h02;
			end
			cart_loader_pkg::HDR_AUTO: begin
				rom_size_addr = '0;
				fixed_mode    = 1'b0;
				type_nxt      = dl.data[15:8];
			end
			default: begin
				rom_size_addr = '0;
				fixed_mode    = 1'b0;
			end
		endcase
	end

	// Sizes as they stand after the current word
	always_comb begin
		rom_size_nxt = rom_size_q;
		ram_size_nxt = ram_size_q;
		if (dl.addr == '0) begin
			rom_size_nxt = cart_loader_pkg::DEFAULT_ROM_SIZE;
			ram_size_nxt = 4'h0;
			if (header_mode == cart_loader_pkg::HDR_AUTO && dl.data[7:0] != 8'h00) begin
				{ram_size_nxt, rom_size_nxt} = dl.data[7:0];
			end
		end
		if (fixed_mode && dl.addr == rom_size_addr) begin
			rom_size_nxt = dl.data[11:8];
		end
		if (fixed_mode && dl.addr == ram_size_addr) begin
			ram_size_nxt = dl.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size_q <= cart_loader_pkg::DEFAULT_ROM_SIZE;
			ram_size_q <= 4'h0;
			region_q   <= 1'b0;
			cart       <= '0;
		end else begin
			if (hdr_wr) begin
				rom_size_q    <= rom_size_nxt;
				ram_size_q    <= ram_size_nxt;
				cart.rom_mask <= (24'd1024 << rom_size_nxt) - 24'd1;
				cart.ram_mask <= (ram_size_nxt != 4'h0) ? (24'd1024 << ram_size_nxt) - 24'd1 : '0;
				if (dl.addr == '0) begin
					cart.rom_type <= type_nxt;
				end
				if (dl.addr == 25'd2) begin
					region_q <= dl.data[8];
				end
			end
			// Region only settles once the download is over
			if (!cart_dl) begin
				case (region_mode)
					cart_loader_pkg::REGION_AUTO: cart.pal <= region_q;
					cart_loader_pkg::REGION_NTSC: cart.pal <= 1'b0;
					default:                      cart.pal <= 1'b1;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verification/cart_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none
// Cartridge loader testbench
// Table driven header downloads, a cheat code, RAM clear sweeps and
// backup RAM transfers against a sector responder

module cart_loader_tb;

	localparam int NUM_ROWS      = 7;
	localparam int LOAD_ROW      = 1;
	localparam int FILL_LEN      = (1 << cart_loader_pkg::FILL_ADDR_BITS) + 1;
	localparam int SECTOR_BUDGET = 4000;
	// Each download waits for a whole clear sweep
	localparam int MAX_CYCLES    = (NUM_ROWS + 2) * ((1 << 17) + 200) + SECTOR_BUDGET;

	typedef struct packed {
		cart_loader_pkg::header_mode_t hdr;
		cart_loader_pkg::region_mode_t region;
		logic [15:0]                   word0;
		logic [15:0]                   word2;
		logic [24:0]                   size_addr;
		logic [15:0]                   size_word;
		logic [15:0]                   ram_word;
		logic [7:0]                    exp_type;
		logic [23:0]                   exp_rom_mask;
		logic [23:0]                   exp_ram_mask;
		logic                          exp_pal;
	} header_row_t;

	logic                         clk_sys;
	logic                         reset;
	cart_loader_pkg::dl_bus_t     dl;
	cart_loader_pkg::loader_cfg_t cfg;
	cart_loader_pkg::image_t      image;
	logic                         sd_ack = 1'b0;
	cart_loader_pkg::cart_info_t  cart;
	cart_loader_pkg::cheat_code_t cheat;
	cart_loader_pkg::fill_t       fill;
	cart_loader_pkg::sd_req_t     sd;
	logic                         bk_ena;
	logic                         bk_loading;
	logic                         core_reset;

	header_row_t rows [NUM_ROWS];
	logic [31:0] req_lba [$];
	logic        req_rd [$];
	logic [31:0] lfsr_state = 32'hcfda;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          fill_cycles = 0;
	int          fill_runs = 0;
	int          downloads = 0;
	int          resp_delay;
	int          resp_hold;
	logic        resp_busy = 1'b0;

	cart_loader_top DUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.cfg        (cfg),
		.image      (image),
		.sd_ack     (sd_ack),
		.cart       (cart),
		.cheat      (cheat),
		.fill       (fill),
		.sd         (sd),
		.bk_ena     (bk_ena),
		.bk_loading (bk_loading),
		.core_reset (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==========================================================
	// Checks and helpers
	// ==========================================================
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		assert (got === exp)
		else begin
			error_count++;
			$display("FAIL at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp, got);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		check_count++;
		assert (cond === 1'b1)
		else begin
			error_count++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	// Start-up byte expected at a given clear address
	function automatic logic [7:0] pattern_byte(input cart_loader_pkg::wram_pattern_t p,
		input logic [16:0] a);
		logic [7:0] value;
		if (p == cart_loader_pkg::WRAM_9966) begin
			value = (a[8] != a[2]) ? 8'h66 : 8'h99;
		end else if (p == cart_loader_pkg::WRAM_00FF) begin
			value = (a[9] != a[0]) ? 8'hFF : 8'h00;
		end else if (p == cart_loader_pkg::WRAM_55) begin
			value = 8'h55;
		end else begin
			value = 8'hFF;
		end
		return value;
	endfunction

	// Columns: mode, region, word 0, word 2, size address, size word, RAM word,
	// then expected type, ROM mask, RAM mask, pal
	task automatic load_rows();
		rows[0] = '{cart_loader_pkg::HDR_AUTO, cart_loader_pkg::REGION_AUTO,
			16'h0A00, 16'h0100, 25'h0081D6, 16'h0B00, 16'h0003,
			8'h0A, 24'h3FFFFF, 24'h000000, 1'b1};
		rows[1] = '{cart_loader_pkg::HDR_AUTO, cart_loader_pkg::REGION_NTSC,
			16'h2135, 16'h0100, 25'h0081D6, 16'h0900, 16'h0002,
			8'h21, 24'h007FFF, 24'h001FFF, 1'b0};
		rows[2] = '{cart_loader_pkg::HDR_NONE, cart_loader_pkg::REGION_PAL,
			16'h5533, 16'h0000, 25'h0081D6, 16'h0A00, 16'h0004,
			8'h00, 24'h3FFFFF, 24'h000000, 1'b1};
		rows[3] = '{cart_loader_pkg::HDR_LOROM, cart_loader_pkg::REGION_AUTO,
			16'h7777, 16'h0000, 25'h0081D6, 16'h0A00, 16'h0001,
			8'h00, 24'h0FFFFF, 24'h0007FF, 1'b0};
		rows[4] = '{cart_loader_pkg::HDR_HIROM, cart_loader_pkg::REGION_AUTO,
			16'h1234, 16'h0100, 25'h0101D6, 16'h0B00, 16'h0005,
			8'h01, 24'h1FFFFF, 24'h007FFF, 1'b1};
		rows[5] = '{cart_loader_pkg::HDR_EXHIROM, cart_loader_pkg::REGION_NTSC,
			16'hFFFF, 16'h0100, 25'h4101D6, 16'h0D00, 16'h0000,
			8'h02, 24'h7FFFFF, 24'h000000, 1'b0};
		rows[6] = '{cart_loader_pkg::HDR_LOROM, cart_loader_pkg::REGION_PAL,
			16'h0000, 16'h0000, 25'h0081D6, 16'h0E00, 16'h000E,
			8'h00, 24'hFFFFFF, 24'hFFFFFF, 1'b1};
	endtask

	// ==========================================================
	// Background monitors
	// ==========================================================

	// Sector responder, ack after 1 to 4 cycles
	always begin
		@(negedge clk_sys);
		if (!reset && (sd.rd || sd.wr)) begin
			resp_busy = 1'b1;
			req_lba.push_back(sd.lba);
			req_rd.push_back(sd.rd);
			random_bits(2, resp_delay);
			repeat (resp_delay + 1) @(negedge clk_sys);
			check_true(sd.rd || sd.wr, "sector request dropped before acknowledge");
			check_value("sd.lba", sd.lba, req_lba[$]);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			check_true(!sd.rd && !sd.wr, "sector request still high after acknowledge");
			random_bits(1, resp_hold);
			repeat (resp_hold) @(negedge clk_sys);
			sd_ack = 1'b0;
			resp_busy = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && (sd.rd || sd.wr)) begin
			check_true(!(sd.rd && sd.wr), "sector read and write requested together");
			check_true(bk_loading == sd.rd, "bk_loading does not match the request direction");
		end
	end

	// Clear sweep: address steps, pattern data, core held in reset
	always @(negedge clk_sys) begin
		if (reset) begin
			fill_cycles = 0;
		end else if (fill.active) begin
			check_value("fill.addr", fill.addr, fill_cycles % (1 << 17));
			check_value("fill.wram_data", fill.wram_data,
				pattern_byte(cfg.wram_pattern, 17'(fill_cycles % (1 << 17))));
			check_value("core_reset", core_reset, 1);
			fill_cycles++;
		end else begin
			if (fill_cycles != 0) begin
				check_value("fill.active cycles", fill_cycles, FILL_LEN);
				fill_runs++;
				fill_cycles = 0;
			end
			check_value("fill.addr", fill.addr, 0);
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a test did not finish", cycle_count);
			$display("Checks: %0d  Errors: %0d", check_count, error_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==========================================================
	// Stimulus tasks, all entered on a falling edge
	// ==========================================================
	task automatic write_word(input logic [24:0] a, input logic [15:0] d);
		dl.addr = a;
		dl.data = d;
		dl.wr   = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic do_download(input int r);
		header_row_t row;
		row = rows[r];
		cfg.header_mode  = row.hdr;
		cfg.region_mode  = row.region;
		cfg.wram_pattern = cart_loader_pkg::wram_pattern_t'(r % 4);
		@(negedge clk_sys);
		check_value("fill.active", fill.active, 0);
		dl.index  = cart_loader_pkg::DL_INDEX_CART;
		dl.active = 1'b1;
		@(negedge clk_sys);
		check_value("fill.active", fill.active, 1);
		write_word(25'd0, row.word0);
		write_word(25'd2, row.word2);
		write_word(row.size_addr, row.size_word);
		write_word(row.size_addr + 25'd2, row.ram_word);
		// Extra cycle lets bk_ena see the final RAM mask
		@(negedge clk_sys);
		dl.active = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_cart(input int r);
		check_value("cart.rom_type", cart.rom_type, rows[r].exp_type);
		check_value("cart.rom_mask", cart.rom_mask, rows[r].exp_rom_mask);
		check_value("cart.ram_mask", cart.ram_mask, rows[r].exp_ram_mask);
		check_value("cart.pal", cart.pal, rows[r].exp_pal);
	endtask

	task automatic wait_fill_done(input int target);
		while (fill_runs < target) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_sectors(input int total);
		while (req_lba.size() < total || resp_busy || sd.rd || sd.wr) begin
			@(negedge clk_sys);
		end
		// Quiet window catches any extra request
		repeat (8) @(negedge clk_sys);
	endtask

	task automatic check_sectors(input int base, input int n, input logic want_rd);
		check_value("sector request count", req_lba.size() - base, n);
		for (int i = 0; i < n && base + i < req_lba.size(); i++) begin
			check_value("sd.lba", req_lba[base + i], i);
			check_value("sd.rd", req_rd[base + i], want_rd);
		end
	endtask

	task automatic run_cheat_test();
		logic [15:0] words [8];
		words = '{16'hA1B2, 16'hC3D4, 16'h0123, 16'h4567,
			16'h89AB, 16'hCDEF, 16'h5A5A, 16'hF00D};
		dl.index  = cart_loader_pkg::DL_INDEX_CODE;
		dl.active = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 8; i++) begin
			dl.addr = 25'(2 * i);
			dl.data = words[i];
			dl.wr   = 1'b1;
			@(negedge clk_sys);
			dl.wr = 1'b0;
			check_value("cheat.valid", cheat.valid, i == 7);
			@(negedge clk_sys);
			check_value("cheat.valid", cheat.valid, 0);
		end
		dl.active = 1'b0;
		check_value("cheat.flags", cheat.flags, {words[1], words[0]});
		check_value("cheat.address", cheat.address, {words[3], words[2]});
		check_value("cheat.compare", cheat.compare, {words[5], words[4]});
		check_value("cheat.replace", cheat.replace, {words[7], words[6]});
		check_value("core_reset", core_reset, 0);
	endtask

	task automatic run_load_test();
		int base;
		int n;
		base  = req_lba.size();
		n     = int'(rows[LOAD_ROW].exp_ram_mask[23:9]) + 1;
		image = '{mounted: 1'b1, readonly: 1'b0, size_nonzero: 1'b1};
		do_download(LOAD_ROW);
		check_cart(LOAD_ROW);
		check_value("bk_ena", bk_ena, 1);
		check_value("bk_loading", bk_loading, 1);
		while (bk_loading) begin
			@(negedge clk_sys);
		end
		wait_sectors(base + n);
		check_sectors(base, n, 1'b1);
		downloads++;
		wait_fill_done(downloads);
	endtask

	task automatic run_save_test();
		int base;
		int n;
		base = req_lba.size();
		n    = int'(rows[LOAD_ROW].exp_ram_mask[23:9]) + 1;
		cfg.bk_save = 1'b1;
		@(negedge clk_sys);
		check_value("sd.wr", sd.wr, 1);
		check_value("bk_loading", bk_loading, 0);
		wait_sectors(base + n);
		check_sectors(base, n, 1'b0);
		cfg.bk_save = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic run_readonly_test();
		int base;
		base = req_lba.size();
		image.readonly = 1'b1;
		do_download(LOAD_ROW);
		check_cart(LOAD_ROW);
		check_value("bk_ena", bk_ena, 0);
		check_value("bk_loading", bk_loading, 0);
		cfg.bk_save = 1'b1;
		repeat (20) @(negedge clk_sys);
		check_value("sector request count", req_lba.size() - base, 0);
		check_value("bk_ena", bk_ena, 0);
		cfg.bk_save = 1'b0;
		downloads++;
		wait_fill_done(downloads);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial begin
		load_rows();
		reset = 1'b1;
		dl    = '0;
		cfg   = '0;
		image = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_value("sd.rd", sd.rd, 0);
		check_value("sd.wr", sd.wr, 0);
		check_value("fill.active", fill.active, 0);
		check_value("cheat.valid", cheat.valid, 0);
		check_value("bk_ena", bk_ena, 0);
		check_value("bk_loading", bk_loading, 0);

		run_cheat_test();

		// Header rows, no backup image mounted
		for (int r = 0; r < NUM_ROWS; r++) begin
			do_download(r);
			check_cart(r);
			downloads++;
			wait_fill_done(downloads);
		end

		run_load_test();
		run_save_test();
		run_readonly_test();

		$display("Checks: %0d  Errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/cart_loader_pkg.sv
hdl/rom_header_detect.sv
hdl/cheat_code_assembler.sv
hdl/ram_clear_fill.sv
hdl/backup_sector_sequencer.sv
hdl/cart_loader_top.sv
verification/cart_loader_tb.sv
